//--- design/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// sample width for pixels, weights and biases
`define WORD 16

// square image, one side
`define IMG_W 5

`define IN_CH 2
`define OUT_CH 2

// 3x3 kernel positions
`define KERNEL_TAPS 9

// fixed point fraction bits
`define FRAC_BITS 8

`endif

//--- design/conv_pkg.sv
`default_nettype none

`include "conv_params.svh"

package conv_pkg;

	typedef logic signed [`WORD-1:0] sample_t;

	// one pixel or one weight word, input channel i in slice i
	typedef logic [`IN_CH*`WORD-1:0] channel_vec_t;

	// output channel ch in slice ch
	typedef logic [`OUT_CH*`WORD-1:0] out_vec_t;

	typedef logic signed [39:0] acc_t;

	typedef logic [15:0] addr_t;

	typedef enum logic {SCAN_IDLE, SCAN_RUN} scan_state_t;

endpackage

`default_nettype wire

//--- design/coef_chain.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module coef_chain #(
	parameter int DEPTH = `KERNEL_TAPS * `OUT_CH,
	parameter int WIDTH = `IN_CH * `WORD
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   store_done,
	input  logic [WIDTH-1:0]       rd_data,
	output logic                   rd,
	output conv_pkg::addr_t        rd_addr,
	output logic [DEPTH*WIDTH-1:0] coefs,
	output logic                   loaded
);

	localparam conv_pkg::addr_t LAST_ADDR = conv_pkg::addr_t'(DEPTH - 1);

	// strobe delayed to line up with the returning word
	logic rd_d;
	logic [WIDTH-1:0] chain [DEPTH];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			rd <= 1'b0;
			rd_addr <= '0;
		end
		else if (rd)
		begin
			if (rd_addr == LAST_ADDR)
			begin
				rd <= 1'b0;
				rd_addr <= '0;
			end
			else
				rd_addr <= rd_addr + 16'd1;
		end
		else if (store_done && !rd_d && !loaded)
			rd <= 1'b1;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			rd_d <= 1'b0;
			loaded <= 1'b0;
			for (int i = 0; i < DEPTH; i++)
				chain[i] <= '0;
		end
		else
		begin
			rd_d <= rd;
			// last word arrives one cycle after the final strobe
			if (rd_d && !rd)
				loaded <= 1'b1;
			// new word enters at the top, word 0 ends at position 0
			if (rd_d)
			begin
				for (int i = 0; i < DEPTH - 1; i++)
					chain[i] <= chain[i + 1];
				chain[DEPTH - 1] <= rd_data;
			end
		end
	end

	for (genvar a = 0; a < DEPTH; a++)
	begin : g_flat
		assign coefs[a*WIDTH +: WIDTH] = chain[a];
	end

	a_no_reload: assert property (@(posedge clk) disable iff (rst) loaded |=> !rd)
		else $error("coefficient read strobe after load finished");

endmodule

`default_nettype wire

//--- design/conv_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module conv_window (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  pix_valid,
	input  conv_pkg::channel_vec_t                pix_data,
	output logic [`KERNEL_TAPS*`IN_CH*`WORD-1:0]  window
);

	localparam int CH_W = `IN_CH * `WORD;
	localparam int LB_LEN = `IMG_W - 3;

	// tap t = 3*row + col, top-left is tap 0
	conv_pkg::channel_vec_t win [`KERNEL_TAPS];

	// word entering the right end of each window row
	conv_pkg::channel_vec_t row_in [3];

	assign row_in[2] = pix_data;

	// line buffer k carries row k+1's leftmost word up to row k
	for (genvar k = 0; k < 2; k++)
	begin : g_line
		if (LB_LEN > 0)
		begin : g_buf
			conv_pkg::channel_vec_t stage [LB_LEN];

			always_ff @(posedge clk or posedge rst)
			begin
				if (rst)
				begin
					for (int i = 0; i < LB_LEN; i++)
						stage[i] <= '0;
				end
				else if (pix_valid)
				begin
					stage[0] <= win[3*k + 3];
					for (int i = 1; i < LB_LEN; i++)
						stage[i] <= stage[i - 1];
				end
			end

			assign row_in[k] = stage[LB_LEN - 1];
		end
		else
		begin : g_direct
			assign row_in[k] = win[3*k + 3];
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int t = 0; t < `KERNEL_TAPS; t++)
				win[t] <= '0;
		end
		else if (pix_valid)
		begin
			for (int r = 0; r < 3; r++)
			begin
				win[3*r + 2] <= row_in[r];
				win[3*r + 1] <= win[3*r + 2];
				win[3*r] <= win[3*r + 1];
			end
		end
	end

	for (genvar t = 0; t < `KERNEL_TAPS; t++)
	begin : g_flat
		assign window[t*CH_W +: CH_W] = win[t];
	end

endmodule

`default_nettype wire

//--- design/conv_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module conv_mac (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic [`KERNEL_TAPS*`IN_CH*`WORD-1:0] window,
	input  logic [`KERNEL_TAPS*`IN_CH*`WORD-1:0] weights,
	input  conv_pkg::sample_t                    bias,
	output conv_pkg::sample_t                    result
);

	// products, padded up to a power of two for the tree
	localparam int N = `KERNEL_TAPS * `IN_CH;
	localparam int P = 1 << $clog2(N);

	conv_pkg::acc_t sum;
	conv_pkg::acc_t scaled;

	always_comb
	begin : adder_tree
		conv_pkg::acc_t node [2*P - 1];
		conv_pkg::sample_t px;
		conv_pkg::sample_t wt;
		// leaves sit at P-1 .. 2P-2, root at 0
		for (int j = 0; j < N; j++)
		begin
			px = window[j*`WORD +: `WORD];
			wt = weights[j*`WORD +: `WORD];
			node[P - 1 + j] = conv_pkg::acc_t'(px) * conv_pkg::acc_t'(wt);
		end
		for (int j = N; j < P; j++)
			node[P - 1 + j] = '0;
		for (int j = P - 2; j >= 0; j--)
			node[j] = node[2*j + 1] + node[2*j + 2];
		sum = node[0];
	end

	assign scaled = sum >>> `FRAC_BITS;

	// wraps on overflow
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			result <= '0;
		else
			result <= scaled[`WORD-1:0] + bias;
	end

endmodule

`default_nettype wire

//--- design/scan_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module scan_ctrl (
	input  logic            clk,
	input  logic            rst,
	input  logic            pixel_store_done,
	output logic            pixel_rd,
	output conv_pkg::addr_t pixel_addr,
	output logic            pix_valid,
	output logic            out_valid,
	output conv_pkg::addr_t out_row,
	output conv_pkg::addr_t out_col,
	output logic            layer_done
);

	localparam conv_pkg::addr_t LAST = conv_pkg::addr_t'(`IMG_W - 1);
	localparam conv_pkg::addr_t OUT_LIM = conv_pkg::addr_t'(`IMG_W - 2);
	// first row or column that completes a window
	localparam conv_pkg::addr_t FIRST_FULL = conv_pkg::addr_t'(2);

	conv_pkg::scan_state_t state;

	conv_pkg::addr_t scan_row;
	conv_pkg::addr_t scan_col;
	logic scan_last;

	// position of the pixel arriving with pix_valid
	conv_pkg::addr_t pv_row;
	conv_pkg::addr_t pv_col;
	logic pv_full;
	logic pv_last;

	// window stage, lines up with the window registers
	logic win_valid;
	logic win_last;
	conv_pkg::addr_t win_row;
	conv_pkg::addr_t win_col;

	assign scan_last = (scan_row == LAST) && (scan_col == LAST);
	assign pv_full = pix_valid && (pv_row >= FIRST_FULL) && (pv_col >= FIRST_FULL);
	assign pv_last = pix_valid && (pv_row == LAST) && (pv_col == LAST);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= conv_pkg::SCAN_IDLE;
			pixel_rd <= 1'b0;
			pixel_addr <= '0;
			scan_row <= '0;
			scan_col <= '0;
		end
		else
		begin
			case (state)
				conv_pkg::SCAN_IDLE:
				begin
					if (pixel_store_done)
					begin
						state <= conv_pkg::SCAN_RUN;
						pixel_rd <= 1'b1;
					end
				end
				conv_pkg::SCAN_RUN:
				begin
					if (pixel_rd)
					begin
						if (scan_last)
						begin
							pixel_rd <= 1'b0;
							pixel_addr <= '0;
							scan_row <= '0;
							scan_col <= '0;
						end
						else
						begin
							pixel_addr <= pixel_addr + 16'd1;
							if (scan_col == LAST)
							begin
								scan_col <= '0;
								scan_row <= scan_row + 16'd1;
							end
							else
								scan_col <= scan_col + 16'd1;
						end
					end
					// back to idle as the final window leaves the mac
					if (win_last)
						state <= conv_pkg::SCAN_IDLE;
				end
				default:
					state <= conv_pkg::SCAN_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pix_valid <= 1'b0;
			pv_row <= '0;
			pv_col <= '0;
			win_valid <= 1'b0;
			win_last <= 1'b0;
			win_row <= '0;
			win_col <= '0;
			out_valid <= 1'b0;
			layer_done <= 1'b0;
			out_row <= '0;
			out_col <= '0;
		end
		else
		begin
			pix_valid <= pixel_rd;
			pv_row <= scan_row;
			pv_col <= scan_col;
			win_valid <= pv_full;
			win_last <= pv_last;
			if (pv_full)
			begin
				win_row <= pv_row - FIRST_FULL;
				win_col <= pv_col - FIRST_FULL;
			end
			out_valid <= win_valid;
			layer_done <= win_last;
			if (win_valid)
			begin
				out_row <= win_row;
				out_col <= win_col;
			end
		end
	end

	a_out_range: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> (out_row < OUT_LIM) && (out_col < OUT_LIM))
		else $error("output position outside the valid window range");

endmodule

`default_nettype wire

//--- design/conv_layer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module conv_layer (
	input  logic                   clk,
	input  logic                   rst,
	input  conv_pkg::channel_vec_t pixel_data,
	input  conv_pkg::channel_vec_t weight_data,
	input  conv_pkg::sample_t      bias_data,
	input  logic                   weight_store_done,
	input  logic                   bias_store_done,
	input  logic                   pixel_store_done,
	output logic                   pixel_rd,
	output conv_pkg::addr_t        pixel_addr,
	output logic                   weight_rd,
	output conv_pkg::addr_t        weight_addr,
	output logic                   bias_rd,
	output conv_pkg::addr_t        bias_addr,
	output logic                   out_valid,
	output conv_pkg::addr_t        out_row,
	output conv_pkg::addr_t        out_col,
	output conv_pkg::out_vec_t     out_data,
	output logic                   layer_done
);

	localparam int CH_W = `IN_CH * `WORD;
	localparam int WDEPTH = `KERNEL_TAPS * `OUT_CH;

	logic pix_valid;
	logic [`KERNEL_TAPS*CH_W-1:0] window;
	logic [WDEPTH*CH_W-1:0] weight_coefs;
	logic [`OUT_CH*`WORD-1:0] bias_coefs;
	logic weight_loaded;
	logic bias_loaded;

	scan_ctrl u_scan_ctrl (
		.clk              (clk),
		.rst              (rst),
		.pixel_store_done (pixel_store_done),
		.pixel_rd         (pixel_rd),
		.pixel_addr       (pixel_addr),
		.pix_valid        (pix_valid),
		.out_valid        (out_valid),
		.out_row          (out_row),
		.out_col          (out_col),
		.layer_done       (layer_done)
	);

	conv_window u_conv_window (
		.clk       (clk),
		.rst       (rst),
		.pix_valid (pix_valid),
		.pix_data  (pixel_data),
		.window    (window)
	);

	coef_chain #(
		.DEPTH (WDEPTH),
		.WIDTH (CH_W)
	) u_weight_chain (
		.clk        (clk),
		.rst        (rst),
		.store_done (weight_store_done),
		.rd_data    (weight_data),
		.rd         (weight_rd),
		.rd_addr    (weight_addr),
		.coefs      (weight_coefs),
		.loaded     (weight_loaded)
	);

	coef_chain #(
		.DEPTH (`OUT_CH),
		.WIDTH (`WORD)
	) u_bias_chain (
		.clk        (clk),
		.rst        (rst),
		.store_done (bias_store_done),
		.rd_data    (bias_data),
		.rd         (bias_rd),
		.rd_addr    (bias_addr),
		.coefs      (bias_coefs),
		.loaded     (bias_loaded)
	);

	for (genvar ch = 0; ch < `OUT_CH; ch++)
	begin : g_mac
		logic [`KERNEL_TAPS*CH_W-1:0] ch_weights;

		// weight word for tap t, channel ch sits at t*OUT_CH + ch
		for (genvar t = 0; t < `KERNEL_TAPS; t++)
		begin : g_tap
			assign ch_weights[t*CH_W +: CH_W] = weight_coefs[(t*`OUT_CH + ch)*CH_W +: CH_W];
		end

		conv_mac u_conv_mac (
			.clk     (clk),
			.rst     (rst),
			.window  (window),
			.weights (ch_weights),
			.bias    (bias_coefs[ch*`WORD +: `WORD]),
			.result  (out_data[ch*`WORD +: `WORD])
		);
	end

	a_loaded_first: assert property (@(posedge clk) disable iff (rst)
		$rose(pixel_rd) |-> weight_loaded && bias_loaded)
		else $error("pixel scan started before coefficients were loaded");

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 40
) (
	output logic clk
);

	initial
		clk = 1'b0;

	always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- test/tb_conv_layer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_params.svh"

module tb_conv_layer;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int COEF_WAIT = 25;
	localparam int TAIL_CYCLES = 10;
	localparam int CH_W = `IN_CH * `WORD;
	localparam int OUT_BITS = `OUT_CH * `WORD;
	localparam int VEC_W = (CH_W > OUT_BITS) ? CH_W : OUT_BITS;
	localparam int WEIGHT_DEPTH = `KERNEL_TAPS * `OUT_CH;
	localparam int NUM_PIX = `IMG_W * `IMG_W;
	localparam int OUT_SIDE = `IMG_W - 2;
	localparam int NUM_OUT = OUT_SIDE * OUT_SIDE;
	localparam int NUM_VEC = WEIGHT_DEPTH + `OUT_CH + NUM_PIX + NUM_OUT;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + COEF_WAIT + 2 * NUM_PIX + 20;

	logic clk;
	logic rst;
	conv_pkg::channel_vec_t pixel_data;
	conv_pkg::channel_vec_t weight_data;
	conv_pkg::sample_t bias_data;
	logic weight_store_done;
	logic bias_store_done;
	logic pixel_store_done;
	logic pixel_rd;
	conv_pkg::addr_t pixel_addr;
	logic weight_rd;
	conv_pkg::addr_t weight_addr;
	logic bias_rd;
	conv_pkg::addr_t bias_addr;
	logic out_valid;
	conv_pkg::addr_t out_row;
	conv_pkg::addr_t out_col;
	conv_pkg::out_vec_t out_data;
	logic layer_done;

	logic [VEC_W-1:0] vectors [NUM_VEC];
	conv_pkg::channel_vec_t weight_mem [WEIGHT_DEPTH];
	conv_pkg::sample_t bias_mem [`OUT_CH];
	conv_pkg::channel_vec_t pix_mem [NUM_PIX];
	conv_pkg::out_vec_t exp_mem [NUM_OUT];

	// strobes seen in the previous cycle, answered in this one
	logic weight_pend;
	logic bias_pend;
	logic pix_pend;
	int weight_pend_addr;
	int bias_pend_addr;
	int pix_pend_addr;

	int cycle = 0;
	int weight_count = 0;
	int weight_first = 0;
	int bias_count = 0;
	int bias_first = 0;
	int pixel_count = 0;
	int pixel_first = 0;
	int out_count = 0;
	logic done_seen = 1'b0;

	tb_clock #(
		.PERIOD_NS (CLK_PERIOD)
	) u_tb_clock (
		.clk (clk)
	);

	conv_layer u_conv_layer (
		.clk               (clk),
		.rst               (rst),
		.pixel_data        (pixel_data),
		.weight_data       (weight_data),
		.bias_data         (bias_data),
		.weight_store_done (weight_store_done),
		.bias_store_done   (bias_store_done),
		.pixel_store_done  (pixel_store_done),
		.pixel_rd          (pixel_rd),
		.pixel_addr        (pixel_addr),
		.weight_rd         (weight_rd),
		.weight_addr       (weight_addr),
		.bias_rd           (bias_rd),
		.bias_addr         (bias_addr),
		.out_valid         (out_valid),
		.out_row           (out_row),
		.out_col           (out_col),
		.out_data          (out_data),
		.layer_done        (layer_done)
	);

	task abort_run(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task next_cycle();
		@(posedge clk);
		#2;
	endtask

	task load_vectors();
		$readmemh("test/conv_vectors.hex", vectors);
		for (int i = 0; i < WEIGHT_DEPTH; i++)
			weight_mem[i] = vectors[i][CH_W-1:0];
		for (int i = 0; i < `OUT_CH; i++)
			bias_mem[i] = vectors[WEIGHT_DEPTH + i][`WORD-1:0];
		for (int i = 0; i < NUM_PIX; i++)
			pix_mem[i] = vectors[WEIGHT_DEPTH + `OUT_CH + i][CH_W-1:0];
		for (int i = 0; i < NUM_OUT; i++)
			exp_mem[i] = vectors[WEIGHT_DEPTH + `OUT_CH + NUM_PIX + i][OUT_BITS-1:0];
	endtask

	task pulse_coef_stores();
		next_cycle();
		weight_store_done = 1'b1;
		bias_store_done = 1'b1;
		next_cycle();
		weight_store_done = 1'b0;
		bias_store_done = 1'b0;
	endtask

	task start_scan();
		next_cycle();
		pixel_store_done = 1'b1;
		next_cycle();
		pixel_store_done = 1'b0;
	endtask

	// one strobe per cycle, addresses counting up from 0, never past depth
	task automatic check_read_strobe(input string name, input logic rd, input int addr,
		input int depth, inout int count, inout int first);
		if (rd)
		begin
			assert (count < depth)
				else abort_run($sformatf("%s_rd strobed again after all %0d words were read",
					name, depth));
			assert (addr == count)
				else abort_run($sformatf("Fail %s_addr got %h expected %h", name, addr, count));
			if (count == 0)
				first = cycle;
			assert (cycle == first + count)
				else abort_run($sformatf("%s_rd strobes are not on consecutive cycles", name));
			count++;
		end
	endtask

	task check_output();
		int exp_row;
		int exp_col;
		int pix_index;
		if (out_valid)
		begin
			assert (out_count < NUM_OUT)
				else abort_run("out_valid pulsed more often than there are windows");
			exp_row = out_count / OUT_SIDE;
			exp_col = out_count % OUT_SIDE;
			assert (int'(out_row) == exp_row)
				else abort_run($sformatf("Fail out_row got %h expected %h", out_row, exp_row));
			assert (int'(out_col) == exp_col)
				else abort_run($sformatf("Fail out_col got %h expected %h", out_col, exp_col));
			// bottom-right pixel of this window
			pix_index = (exp_row + 2) * `IMG_W + exp_col + 2;
			assert (pixel_count > pix_index)
				else abort_run("out_valid came before the window's last pixel was read");
			assert (cycle == pixel_first + pix_index + 3)
				else abort_run($sformatf("Fail out_valid cycle got %h expected %h",
					cycle, pixel_first + pix_index + 3));
			assert (out_data == exp_mem[out_count])
				else abort_run($sformatf("Fail out_data got %h expected %h",
					out_data, exp_mem[out_count]));
			assert (layer_done == (out_count == NUM_OUT - 1))
				else abort_run($sformatf("Fail layer_done got %h expected %h",
					layer_done, out_count == NUM_OUT - 1));
			if (layer_done)
				done_seen = 1'b1;
			out_count++;
		end
		else
		begin
			assert (!layer_done)
				else abort_run("layer_done was high without out_valid");
		end
	endtask

	// synchronous memories with one cycle of read latency
	initial
	begin
		pixel_data = '0;
		weight_data = '0;
		bias_data = '0;
		weight_pend = 1'b0;
		bias_pend = 1'b0;
		pix_pend = 1'b0;
		weight_pend_addr = 0;
		bias_pend_addr = 0;
		pix_pend_addr = 0;
		forever
		begin
			next_cycle();
			weight_data = weight_pend ? weight_mem[weight_pend_addr] : '0;
			bias_data = bias_pend ? bias_mem[bias_pend_addr] : '0;
			pixel_data = pix_pend ? pix_mem[pix_pend_addr] : '0;
			weight_pend = weight_rd;
			weight_pend_addr = int'(weight_addr);
			bias_pend = bias_rd;
			bias_pend_addr = int'(bias_addr);
			pix_pend = pixel_rd;
			pix_pend_addr = int'(pixel_addr);
		end
	end

	initial
	begin
		forever
		begin
			@(posedge clk);
			#1;
			cycle++;
			if (rst)
			begin
				assert (!pixel_rd && !weight_rd && !bias_rd && !out_valid && !layer_done)
					else abort_run("a strobe, out_valid or layer_done was high during reset");
			end
			else
			begin
				check_read_strobe("weight", weight_rd, int'(weight_addr), WEIGHT_DEPTH,
					weight_count, weight_first);
				check_read_strobe("bias", bias_rd, int'(bias_addr), `OUT_CH,
					bias_count, bias_first);
				check_read_strobe("pixel", pixel_rd, int'(pixel_addr), NUM_PIX,
					pixel_count, pixel_first);
				check_output();
			end
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run($sformatf("Timeout after %0d clock periods without finishing the layer",
			WATCHDOG_CYCLES));
	end

	initial
	begin
		rst = 1'b1;
		weight_store_done = 1'b0;
		bias_store_done = 1'b0;
		pixel_store_done = 1'b0;
		load_vectors();
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;
		pulse_coef_stores();
		repeat (20) next_cycle();
		// loads are finished, this pulse must be ignored
		pulse_coef_stores();
		next_cycle();
		start_scan();
		while (!done_seen)
			next_cycle();
		repeat (TAIL_CYCLES) next_cycle();
		assert (weight_count == WEIGHT_DEPTH)
			else abort_run($sformatf("Fail weight_rd count got %h expected %h",
				weight_count, WEIGHT_DEPTH));
		assert (bias_count == `OUT_CH)
			else abort_run($sformatf("Fail bias_rd count got %h expected %h",
				bias_count, `OUT_CH));
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/conv_vectors.hex
// 18 weight words then 2 biases then 25 pixels in raster order
// and 9 expected out_data words with channel 1 in the upper half of each word
00000100
00000000
00000000
00000000
00000000
00800000
00000000
03000000
00000200
00000000
00000000
00000000
00000000
0000ff00
00000000
00000000
ff000000
00000000
00000010
0000fff0
00010000
00030001
00050002
00070003
00090004
fffe000a
0000000b
0002000c
0004000d
0006000e
fffb0014
fffd0015
ffff7000
00010017
00030018
fff8001e
fffa001f
fffc0020
fffe0021
00000022
fff50028
fff70029
fff9002a
fffb002b
fffd002c
ffd80027
ffde0028
8ffa0029
ffc40048
ffcae01d
ffd0004a
ffaf0069
ffb5006a
ffbb7055

//--- filelist.f
+incdir+design
design/conv_pkg.sv
design/coef_chain.sv
design/conv_window.sv
design/conv_mac.sv
design/scan_ctrl.sv
design/conv_layer.sv
test/tb_clock.sv
test/tb_conv_layer.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f filelist.f --top-module tb_conv_layer

# a nonzero exit from the run must not skip the search below
status=0
output=$(./obj_dir/Vtb_conv_layer 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
	exit 0
fi
echo "simulation failed, exit status $status"
exit 1
